// ==== include/catGame_defs.svh ====
`ifndef CATGAME_DEFS_SVH
`define CATGAME_DEFS_SVH

// board size, cells per side
`define GRID_N 8

// raster counters
`define COUNT_W 10

// cell geometry in raster pixels
`define CELL_X0 222
`define CELL_Y0 35
`define CELL_PITCH 60
`define CELL_SIZE 51

// sync pulses are high below these counts
`define HSYNC_END 96
`define VSYNC_END 2

// row and column the cat starts on
`define CAT_START 3

// 12-bit colours, red in the top nibble
`define COLOR_WHITE 12'hFFF
`define COLOR_GRAY 12'h888
`define COLOR_ORANGE 12'hF80
`define COLOR_BLANK 12'h00F
`define COLOR_WIN 12'h0F0
`define COLOR_LOSE 12'hF00
`define COLOR_FIELD 12'h000

`define WB_DAT_W 8

`endif

// ==== verilog/catGamePkg.sv ====
`include "catGame_defs.svh"

package catGamePkg;

	// game progress, PLAY right after reset
	typedef enum logic [1:0]
	{
		PLAY = 2'd0,
		WIN  = 2'd1,
		LOSE = 2'd2
	} gameState_t;

	// row or column index on the board
	typedef logic [2:0] cellIdx_t;

	// red, green, blue nibbles
	typedef logic [11:0] color_t;

	// one bit per cell at row * 8 + column, set when blocked
	typedef logic [`GRID_N*`GRID_N-1:0] grid_t;

endpackage

// ==== verilog/catMover.sv ====
`timescale 1ns/1ps

module catMover (
	input  catGamePkg::grid_t     grid,
	input  catGamePkg::cellIdx_t  catRow,
	input  catGamePkg::cellIdx_t  catCol,
	output catGamePkg::cellIdx_t  nextRow,
	output catGamePkg::cellIdx_t  nextCol,
	output logic                  trapped
);
	import catGamePkg::*;

	cellIdx_t downRow;
	cellIdx_t upRow;
	cellIdx_t rightCol;
	cellIdx_t leftCol;

	// the cat is off the edge in PLAY, so no neighbour wraps
	assign downRow  = catRow + 3'd1;
	assign upRow    = catRow - 3'd1;
	assign rightCol = catCol + 3'd1;
	assign leftCol  = catCol - 3'd1;

	// fixed order: row+1, row-1, col+1, col-1
	always_comb
	begin
		nextRow = catRow;
		nextCol = catCol;
		trapped = 1'b0;
		if (!grid[{downRow, catCol}])
			nextRow = downRow;
		else if (!grid[{upRow, catCol}])
			nextRow = upRow;
		else if (!grid[{catRow, rightCol}])
			nextCol = rightCol;
		else if (!grid[{catRow, leftCol}])
			nextCol = leftCol;
		else
			trapped = 1'b1;
	end

endmodule

// ==== verilog/boardKeeper.sv ====
`timescale 1ns/1ps
`include "catGame_defs.svh"

module boardKeeper (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cyc,
	input  logic                    stb,
	input  logic                    we,
	input  logic [`WB_DAT_W-1:0]    datIn,
	output logic                    ack,
	output logic [`WB_DAT_W-1:0]    datOut,
	output catGamePkg::grid_t       grid,
	output catGamePkg::cellIdx_t    catRow,
	output catGamePkg::cellIdx_t    catCol,
	output catGamePkg::gameState_t  state
);
	import catGamePkg::*;

	cellIdx_t reqRow;
	cellIdx_t reqCol;
	grid_t    gridNext;
	cellIdx_t nextRow;
	cellIdx_t nextCol;
	logic     trapped;
	logic     busWrite;
	logic     accept;
	logic     onEdge;

	assign reqRow = datIn[5:3];
	assign reqCol = datIn[2:0];

	// board as it would be with the requested block placed
	always_comb
	begin
		gridNext = grid;
		gridNext[{reqRow, reqCol}] = 1'b1;
	end

	catMover u_catMover (
		.grid    (gridNext),
		.catRow  (catRow),
		.catCol  (catCol),
		.nextRow (nextRow),
		.nextCol (nextCol),
		.trapped (trapped)
	);

	// writes act on the same edge that raises ack
	assign busWrite = cyc && stb && we && !ack;
	assign accept   = busWrite && (state == PLAY) && !grid[{reqRow, reqCol}]
		&& !((reqRow == catRow) && (reqCol == catCol));

	// escape when the cat lands on any border cell
	assign onEdge = (nextRow == 3'd0) || (nextRow == cellIdx_t'(`GRID_N - 1))
		|| (nextCol == 3'd0) || (nextCol == cellIdx_t'(`GRID_N - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ack    <= 1'b0;
			grid   <= '0;
			catRow <= cellIdx_t'(`CAT_START);
			catCol <= cellIdx_t'(`CAT_START);
			state  <= PLAY;
		end
		else
		begin
			ack <= cyc && stb && !ack;
			if (busWrite && (state != PLAY))
			begin
				// any write after the game ends starts a fresh board
				grid   <= '0;
				catRow <= cellIdx_t'(`CAT_START);
				catCol <= cellIdx_t'(`CAT_START);
				state  <= PLAY;
			end
			else if (accept)
			begin
				grid <= gridNext;
				if (trapped)
					state <= WIN;
				else
				begin
					catRow <= nextRow;
					catCol <= nextCol;
					if (onEdge)
						state <= LOSE;
				end
			end
		end
	end

	// status word: cat row, cat column, game state
	assign datOut = {catRow, catCol, state};

endmodule

// ==== verilog/cellLocator.sv ====
`timescale 1ns/1ps
`include "catGame_defs.svh"

module cellLocator (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`COUNT_W-1:0]   hCount,
	input  logic [`COUNT_W-1:0]   vCount,
	input  logic                  bright,
	output logic                  inCell,
	output catGamePkg::cellIdx_t  cellRow,
	output catGamePkg::cellIdx_t  cellCol,
	output logic                  brightQ,
	output logic                  hSyncQ,
	output logic                  vSyncQ
);
	import catGamePkg::*;

	logic [3:0] colSpan;
	logic [3:0] rowSpan;

	// hit flag in the top bit, span index below it
	function automatic logic [3:0] findSpan(input logic [`COUNT_W-1:0] pos, input int origin);
		logic [3:0] hit;
		int         lo;
		hit = 4'd0;
		for (int i = 0; i < `GRID_N; i++)
		begin
			lo = origin + i * `CELL_PITCH;
			// cell size is counted inclusively, so the last pixel is lo + size - 1
			if (int'(pos) >= lo && int'(pos) <= lo + `CELL_SIZE - 1)
				hit = {1'b1, 3'(i)};
		end
		return hit;
	endfunction

	// columns follow hCount, rows follow vCount
	assign colSpan = findSpan(hCount, `CELL_X0);
	assign rowSpan = findSpan(vCount, `CELL_Y0);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			inCell  <= 1'b0;
			brightQ <= 1'b0;
			hSyncQ  <= 1'b0;
			vSyncQ  <= 1'b0;
		end
		else
		begin
			inCell  <= colSpan[3] && rowSpan[3];
			brightQ <= bright;
			hSyncQ  <= hCount < `HSYNC_END;
			vSyncQ  <= vCount < `VSYNC_END;
		end
	end

	// index is only looked at when inCell is set
	always_ff @(posedge clk)
	begin
		cellRow <= rowSpan[2:0];
		cellCol <= colSpan[2:0];
	end

endmodule

// ==== verilog/pixelShader.sv ====
`timescale 1ns/1ps
`include "catGame_defs.svh"

module pixelShader (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    inCell,
	input  catGamePkg::cellIdx_t    cellRow,
	input  catGamePkg::cellIdx_t    cellCol,
	input  logic                    brightQ,
	input  logic                    hSyncQ,
	input  logic                    vSyncQ,
	input  catGamePkg::grid_t       grid,
	input  catGamePkg::cellIdx_t    catRow,
	input  catGamePkg::cellIdx_t    catCol,
	input  catGamePkg::gameState_t  state,
	output catGamePkg::color_t      rgb,
	output logic                    hSync,
	output logic                    vSync
);
	import catGamePkg::*;

	color_t pixColor;
	logic   onCat;
	logic   blocked;

	assign onCat   = (cellRow == catRow) && (cellCol == catCol);
	assign blocked = grid[{cellRow, cellCol}];

	// blanking first, then the cell contents, then the background
	always_comb
	begin
		if (!brightQ)
			pixColor = `COLOR_BLANK;
		else if (inCell)
		begin
			if (onCat)
				pixColor = `COLOR_ORANGE;
			else if (blocked)
				pixColor = `COLOR_GRAY;
			else
				pixColor = `COLOR_WHITE;
		end
		else
		begin
			case (state)
				WIN:     pixColor = `COLOR_WIN;
				LOSE:    pixColor = `COLOR_LOSE;
				default: pixColor = `COLOR_FIELD;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rgb   <= `COLOR_BLANK;
			hSync <= 1'b0;
			vSync <= 1'b0;
		end
		else
		begin
			rgb   <= pixColor;
			hSync <= hSyncQ;
			vSync <= vSyncQ;
		end
	end

endmodule

// ==== verilog/catGameTop.sv ====
`timescale 1ns/1ps
`include "catGame_defs.svh"

module catGameTop (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  logic [`WB_DAT_W-1:0]  datIn,
	input  logic [`COUNT_W-1:0]   hCount,
	input  logic [`COUNT_W-1:0]   vCount,
	input  logic                  bright,
	output logic                  ack,
	output logic [`WB_DAT_W-1:0]  datOut,
	output catGamePkg::color_t    rgb,
	output logic                  hSync,
	output logic                  vSync
);
	import catGamePkg::*;

	// board registers shared with the shader
	grid_t      grid;
	cellIdx_t   catRow;
	cellIdx_t   catCol;
	gameState_t state;

	// pixel stage 1 to stage 2
	logic     inCell;
	cellIdx_t cellRow;
	cellIdx_t cellCol;
	logic     brightQ;
	logic     hSyncQ;
	logic     vSyncQ;

	boardKeeper u_boardKeeper (
		.clk    (clk),
		.rst    (rst),
		.cyc    (cyc),
		.stb    (stb),
		.we     (we),
		.datIn  (datIn),
		.ack    (ack),
		.datOut (datOut),
		.grid   (grid),
		.catRow (catRow),
		.catCol (catCol),
		.state  (state)
	);

	cellLocator u_cellLocator (
		.clk     (clk),
		.rst     (rst),
		.hCount  (hCount),
		.vCount  (vCount),
		.bright  (bright),
		.inCell  (inCell),
		.cellRow (cellRow),
		.cellCol (cellCol),
		.brightQ (brightQ),
		.hSyncQ  (hSyncQ),
		.vSyncQ  (vSyncQ)
	);

	pixelShader u_pixelShader (
		.clk     (clk),
		.rst     (rst),
		.inCell  (inCell),
		.cellRow (cellRow),
		.cellCol (cellCol),
		.brightQ (brightQ),
		.hSyncQ  (hSyncQ),
		.vSyncQ  (vSyncQ),
		.grid    (grid),
		.catRow  (catRow),
		.catCol  (catCol),
		.state   (state),
		.rgb     (rgb),
		.hSync   (hSync),
		.vSync   (vSync)
	);

endmodule

// ==== include/catGameModel.svh ====
`ifndef CATGAMEMODEL_SVH
`define CATGAMEMODEL_SVH

`include "catGame_defs.svh"

// shadow of the board registers
catGamePkg::grid_t      mGrid;
catGamePkg::cellIdx_t   mCatRow;
catGamePkg::cellIdx_t   mCatCol;
catGamePkg::gameState_t mState;

function automatic void modelReset();
	mGrid   = '0;
	mCatRow = 3'(`CAT_START);
	mCatCol = 3'(`CAT_START);
	mState  = catGamePkg::PLAY;
endfunction

// one acknowledged write, as the board sees it
function automatic void modelMove(input logic [`WB_DAT_W-1:0] data);
	int dr[4] = '{1, -1, 0, 0};
	int dc[4] = '{0, 0, 1, -1};
	int r;
	int c;
	int nr;
	int nc;
	logic found;
	r = int'(data[5:3]);
	c = int'(data[2:0]);
	found = 1'b0;
	if (mState != catGamePkg::PLAY)
		modelReset();
	else if (!mGrid[r * `GRID_N + c] && !(r == int'(mCatRow) && c == int'(mCatCol)))
	begin
		mGrid[r * `GRID_N + c] = 1'b1;
		for (int k = 0; k < 4; k++)
		begin
			nr = int'(mCatRow) + dr[k];
			nc = int'(mCatCol) + dc[k];
			if (!found && !mGrid[nr * `GRID_N + nc])
			begin
				found = 1'b1;
				mCatRow = 3'(nr);
				mCatCol = 3'(nc);
			end
		end
		if (!found)
			mState = catGamePkg::WIN;
		else if (mCatRow == 3'd0 || mCatCol == 3'd0
			|| mCatRow == 3'(`GRID_N - 1) || mCatCol == 3'(`GRID_N - 1))
			mState = catGamePkg::LOSE;
	end
endfunction

function automatic logic [`WB_DAT_W-1:0] modelStatus();
	return {mCatRow, mCatCol, mState};
endfunction

// expected {rgb, hSync, vSync} for one raster position
function automatic logic [13:0] modelPixel(input int h, input int v, input logic b);
	int row;
	int col;
	logic [11:0] color;
	row = -1;
	col = -1;
	for (int i = 0; i < `GRID_N; i++)
	begin
		if (h >= `CELL_X0 + i * `CELL_PITCH && h < `CELL_X0 + i * `CELL_PITCH + `CELL_SIZE)
			col = i;
		if (v >= `CELL_Y0 + i * `CELL_PITCH && v < `CELL_Y0 + i * `CELL_PITCH + `CELL_SIZE)
			row = i;
	end
	if (!b)
		color = `COLOR_BLANK;
	else if (row >= 0 && col >= 0)
	begin
		if (row == int'(mCatRow) && col == int'(mCatCol))
			color = `COLOR_ORANGE;
		else if (mGrid[row * `GRID_N + col])
			color = `COLOR_GRAY;
		else
			color = `COLOR_WHITE;
	end
	else if (mState == catGamePkg::WIN)
		color = `COLOR_WIN;
	else if (mState == catGamePkg::LOSE)
		color = `COLOR_LOSE;
	else
		color = `COLOR_FIELD;
	return {color, h < `HSYNC_END, v < `VSYNC_END};
endfunction

`endif

// ==== verif/tb_catGame.sv ====
`timescale 1ns/1ps
`include "catGame_defs.svh"

module tb_catGame;
	import catGamePkg::*;

	`include "catGameModel.svh"

	logic                 clk;
	logic                 rst;
	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [`WB_DAT_W-1:0] datIn;
	logic [`COUNT_W-1:0]  hCount;
	logic [`COUNT_W-1:0]  vCount;
	logic                 bright;
	logic                 ack;
	logic [`WB_DAT_W-1:0] datOut;
	color_t               rgb;
	logic                 hSync;
	logic                 vSync;

	int seed = 18007;
	int ackLimit = 16;

	// row in bits 5:3, column in bits 2:0
	// the cat bounces between 3,3 and 4,3 while both get walled in
	logic [`WB_DAT_W-1:0] trapMoves[7] = '{8'h2B, 8'h13, 8'h1C, 8'h1A, 8'h24, 8'h22, 8'h23};

	// fixed raster positions, shown before the random sweep resumes
	int   pixH[$];
	int   pixV[$];
	logic pixB[$];

	catGameTop u_catGameTop (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abortRun();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic writeMove(input logic [`WB_DAT_W-1:0] data);
		int waited;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		datIn = data;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > ackLimit)
			begin
				$display("timeout: no ack for the write of %h at %0t", data, $time);
				abortRun();
			end
		end
		while (!ack);
		modelMove(data);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic readStatus(output logic [`WB_DAT_W-1:0] status);
		int waited;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > ackLimit)
			begin
				$display("timeout: no ack for a status read at %0t", $time);
				abortRun();
			end
		end
		while (!ack);
		status = datOut;
		cyc = 1'b0;
		stb = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic checkStatus();
		logic [`WB_DAT_W-1:0] status;
		readStatus(status);
		assert (status === modelStatus())
		else
		begin
			$display("ERROR at %0t: status %h, expected %h", $time, status, modelStatus());
			abortRun();
		end
	endtask

	task automatic queuePixel(input int h, input int v, input logic b);
		pixH.push_back(h);
		pixV.push_back(v);
		pixB.push_back(b);
	endtask

	task automatic idleCycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// pixel sweep: new position 1 ns after each edge, compare at the falling edge
	initial
	begin
		int          waited;
		int          lastH;
		int          lastV;
		logic        lastB;
		int          nextH;
		int          nextV;
		logic        nextB;
		int          predH;
		int          predV;
		logic [13:0] expectPix;
		logic [13:0] seenPix;
		logic        havePred;
		hCount = '0;
		vCount = '0;
		bright = 1'b0;
		nextH = 0;
		nextV = 0;
		nextB = 1'b0;
		predH = 0;
		predV = 0;
		expectPix = '0;
		havePred = 1'b0;
		waited = 0;
		do
		begin
			@(negedge clk);
			waited++;
			if (waited > 20)
			begin
				$display("reset was never released");
				abortRun();
			end
		end
		while (rst);
		forever
		begin
			@(posedge clk);
			#1;
			// the position stage 1 took on this edge
			lastH = int'(hCount);
			lastV = int'(vCount);
			lastB = bright;
			hCount = 10'(nextH);
			vCount = 10'(nextV);
			bright = nextB;
			@(negedge clk);
			seenPix = {rgb, hSync, vSync};
			if (havePred)
			begin
				assert (seenPix === expectPix)
				else
				begin
					$display("ERROR at %0t: pixel h %0d v %0d gave rgb %h hSync %b vSync %b",
						$time, predH, predV, seenPix[13:2], seenPix[1], seenPix[0]);
					$display("      expected rgb %h hSync %b vSync %b",
						expectPix[13:2], expectPix[1], expectPix[0]);
					abortRun();
				end
			end
			// stage 2 shades that position on the next edge with the board as it is now
			expectPix = modelPixel(lastH, lastV, lastB);
			predH = lastH;
			predV = lastV;
			havePred = 1'b1;
			if (pixH.size() > 0)
			begin
				nextH = pixH.pop_front();
				nextV = pixV.pop_front();
				nextB = pixB.pop_front();
			end
			else
			begin
				nextH = $unsigned($random(seed)) % 800;
				nextV = $unsigned($random(seed)) % 525;
				nextB = (($random(seed) & 7) != 0);
			end
		end
	end

	initial
	begin
		logic [`WB_DAT_W-1:0] data;
		int                   moves;
		int                   losses;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		datIn = '0;
		losses = 0;
		modelReset();
		repeat (4) @(posedge clk);
		#1;
		assert (rgb === `COLOR_BLANK && hSync === 1'b0 && vSync === 1'b0 && ack === 1'b0)
		else
		begin
			$display("ERROR at %0t: after reset rgb %h hSync %b vSync %b ack %b",
				$time, rgb, hSync, vSync, ack);
			abortRun();
		end
		rst = 1'b0;

		// centre start, cat cell, a far cell, blanking and the cell 7,7 border
		checkStatus();
		queuePixel(427, 240, 1'b1);
		queuePixel(247, 60, 1'b1);
		queuePixel(427, 240, 1'b0);
		queuePixel(692, 505, 1'b1);
		queuePixel(693, 505, 1'b1);
		idleCycles(10);

		// the cat's own cell is refused
		writeMove({2'b00, mCatRow, mCatCol});
		checkStatus();

		foreach (trapMoves[i])
		begin
			writeMove(trapMoves[i]);
			checkStatus();
		end
		assert (mState == WIN)
		else
		begin
			$display("the trapping sequence did not end the game in a win");
			abortRun();
		end
		idleCycles(60);
		writeMove(8'h00);
		checkStatus();

		for (int g = 0; g < 6; g++)
		begin
			moves = 0;
			while (mState == PLAY && moves < 40)
			begin
				data = {2'b00, 6'($random(seed))};
				writeMove(data);
				checkStatus();
				// same cell again, now blocked or under the cat
				if (mState == PLAY)
				begin
					writeMove(data);
					checkStatus();
				end
				moves++;
			end
			if (mState == LOSE)
				losses++;
			if (mState != PLAY)
			begin
				idleCycles(40);
				writeMove(8'h3F);
				checkStatus();
			end
		end
		assert (losses > 0)
		else
		begin
			$display("no random game ended with the cat escaping");
			abortRun();
		end
		idleCycles(20);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
verilog/catGamePkg.sv
verilog/catMover.sv
verilog/boardKeeper.sv
verilog/cellLocator.sv
verilog/pixelShader.sv
verilog/catGameTop.sv
verif/tb_catGame.sv

// ==== run.sh ====
#!/bin/sh
# build and run the catGame testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_catGame \
	-f tb.f -o simv > build.log 2>&1; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ "$simStatus" -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
